// ==== rom_arbiter_defines.svh ====
`ifndef ROM_ARBITER_DEFINES_SVH
`define ROM_ARBITER_DEFINES_SVH

// ------------------------------
// bus widths
// ------------------------------
`define ADDR_W       24   // console / mcu byte address
`define ROM_WADDR_W  23   // rom word address
`define ROM_DATA_W   16
`define MCU_DATA_W   8

// ------------------------------
// timing
// ------------------------------
// delay counter load, access state lasts one more cycle than this
`define ROM_CYCLE_LEN  7

// CLK2 cycles with cpu clock low before the console is dead (about 1 ms)
`define DEAD_TIMEOUT   85714

`define SYNC_DEPTH     7  // cpu clock shift register

`endif

// ==== snes_bus_pkg.sv ====
`include "rom_arbiter_defines.svh"

package snes_bus_pkg;

  // address after the mapper, byte granular
  typedef logic [`ADDR_W-1:0] snes_addr_t;

  // console bus view in the CLK2 domain
  typedef struct packed {
    logic cycle_start;  // cpu clock rose after a full low phase
    logic cycle_end;    // cpu clock fell after a full high phase
    logic free_slot;    // rom may be given to a requester
    logic dead;         // cpu clock stuck low
    logic clk_high;     // synced cpu clock level
  } bus_evt_t;

endpackage

// ==== rom_req_pkg.sv ====
`include "rom_arbiter_defines.svh"

package rom_req_pkg;
  import snes_bus_pkg::*;

  // gsu rom fetch, byte or word
  typedef struct packed {
    snes_addr_t addr;
    logic       word;
  } gsu_req_t;

  // mcu single byte access
  typedef struct packed {
    snes_addr_t             addr;
    logic                   write;
    logic [`MCU_DATA_W-1:0] wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [`ROM_WADDR_W-1:0] addr;
    logic                    we_n;
    logic                    bhe_n;  // upper lane [15:8]
    logic                    ble_n;  // lower lane [7:0]
    logic [`ROM_DATA_W-1:0]  wdata;
  } rom_pins_t;

  typedef enum logic [2:0] {IDLE, GSU_RD, MCU_RD, MCU_WR, END} rom_state_t;

endpackage

// ==== snes_bus_sync.sv ====
`timescale 1ns/10ps
`include "rom_arbiter_defines.svh"

module snes_bus_sync import snes_bus_pkg::*; #(
  parameter int dead_timeout = `DEAD_TIMEOUT
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     cpu_clk_in,
  input  logic     rom_hit,
  input  logic     gsu_ron,
  output bus_evt_t evt
);

  localparam int CNT_W = $clog2(dead_timeout + 2);

  logic [`SYNC_DEPTH-1:0] cpu_clk_sr;
  logic                   clk_high;
  logic                   start_hit;
  logic                   end_hit;
  logic                   cycle_start;
  logic                   cycle_end;
  logic                   free_strobe;
  logic                   gsu_ron_q;
  logic                   dead;
  logic [CNT_W-1:0]       low_cnt;

  // ------------------------------
  // cpu clock edges
  // ------------------------------
  assign clk_high = cpu_clk_sr[1];

  // five samples of one level, then the other
  assign start_hit = (cpu_clk_sr[`SYNC_DEPTH-1:1] == {{(`SYNC_DEPTH-2){1'b0}}, 1'b1});
  assign end_hit   = (cpu_clk_sr[`SYNC_DEPTH-1:1] == {{(`SYNC_DEPTH-2){1'b1}}, 1'b0});

  always_ff @(posedge clk) begin
    if (rst) begin
      cpu_clk_sr  <= '0;
      cycle_start <= 1'b0;
      cycle_end   <= 1'b0;
      gsu_ron_q   <= 1'b0;
      free_strobe <= 1'b0;
    end else begin
      cpu_clk_sr  <= {cpu_clk_sr[`SYNC_DEPTH-2:0], cpu_clk_in};
      cycle_start <= start_hit;
      cycle_end   <= end_hit;
      if (cycle_end) gsu_ron_q <= gsu_ron;  // only change ownership between cycles
      // console not on rom this cycle, or gsu holds the rom bus
      if (gsu_ron_q) free_strobe <= 1'b1;
      else if (cycle_start) free_strobe <= ~rom_hit;
      else free_strobe <= 1'b0;
    end
  end

  // ------------------------------
  // dead console
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst || clk_high) begin
      low_cnt <= '0;
      dead    <= 1'b0;
    end else begin
      if (low_cnt <= CNT_W'(dead_timeout)) low_cnt <= low_cnt + 1'b1;  // saturates
      if (low_cnt > CNT_W'(dead_timeout)) dead <= 1'b1;
    end
  end

  always_comb begin
    evt.cycle_start = cycle_start;
    evt.cycle_end   = cycle_end;
    evt.free_slot   = cycle_end | free_strobe;
    evt.dead        = dead;
    evt.clk_high    = clk_high;
  end

endmodule

// ==== req_slot.sv ====
`timescale 1ns/10ps
`include "rom_arbiter_defines.svh"

module req_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  payload_t payload,
  input  logic     done,
  output logic     rdy,
  output logic     pend,
  output payload_t held
);

  // pending flag and ready are complements except during reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= 1'b0;
      rdy  <= 1'b1;
    end else if (req) begin
      pend <= 1'b1;
      rdy  <= 1'b0;
    end else if (done) begin
      pend <= 1'b0;
      rdy  <= 1'b1;  // read data already captured
    end
  end

  // payload only taken on a strobe
  always_ff @(posedge clk) begin
    if (req) held <= payload;
  end

endmodule

// ==== rom_sequencer.sv ====
`timescale 1ns/10ps
`include "rom_arbiter_defines.svh"

module rom_sequencer import snes_bus_pkg::*, rom_req_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  bus_evt_t               evt,
  input  snes_addr_t             mapped_addr,
  input  logic                   gsu_pend,
  input  gsu_req_t               gsu_held,
  input  logic                   mcu_pend,
  input  mcu_req_t               mcu_held,
  output logic                   gsu_done,
  output logic                   mcu_done,
  output rom_pins_t              rom,
  input  logic [`ROM_DATA_W-1:0] rom_rdata,
  output logic [`ROM_DATA_W-1:0] gsu_rdata,
  output logic [`MCU_DATA_W-1:0] mcu_rdata
);

  localparam int DLY_W = $clog2(`ROM_CYCLE_LEN + 1);

  rom_state_t       state;
  logic [DLY_W-1:0] delay;
  logic             own_gsu;   // owner of the current / last access
  logic             gsu_acc;
  logic             mcu_acc;
  logic             word_rd;
  snes_addr_t       acc_addr;
  logic             addr0_q;

  assign gsu_acc = (state == GSU_RD);
  assign mcu_acc = (state == MCU_RD) || (state == MCU_WR);
  assign word_rd = gsu_acc & gsu_held.word;

  // ------------------------------
  // arbitration
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      delay   <= '0;
      own_gsu <= 1'b0;
    end else if (evt.dead && evt.clk_high) begin
      state <= IDLE;  // console woke up, pending request runs again
    end else begin
      case (state)
        IDLE: begin
          if (evt.free_slot || evt.dead) begin
            if (gsu_pend) begin
              state   <= GSU_RD;
              own_gsu <= 1'b1;
              delay   <= DLY_W'(`ROM_CYCLE_LEN);
            end else if (mcu_pend) begin
              state   <= mcu_held.write ? MCU_WR : MCU_RD;
              own_gsu <= 1'b0;
              delay   <= DLY_W'(`ROM_CYCLE_LEN);
            end
          end
        end
        GSU_RD, MCU_RD, MCU_WR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= END;
        end
        END:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign gsu_done = (state == END) & own_gsu;
  assign mcu_done = (state == END) & ~own_gsu;

  // ------------------------------
  // rom pins
  // ------------------------------
  always_comb begin
    if (gsu_acc) acc_addr = gsu_held.addr;
    else if (mcu_acc) acc_addr = mcu_held.addr;
    else acc_addr = mapped_addr;  // console passthrough
  end

  always_comb begin
    rom.addr  = acc_addr[`ADDR_W-1:1];
    rom.we_n  = (state != MCU_WR);
    // odd byte lives on [7:0]
    rom.bhe_n = acc_addr[0] & ~word_rd;
    rom.ble_n = ~acc_addr[0] & ~word_rd;
    rom.wdata = {2{mcu_held.wdata}};  // lane enables pick the byte
  end

  // read data, last sample of the access wins
  always_ff @(posedge clk) begin
    addr0_q <= acc_addr[0];
    if (gsu_acc) begin
      gsu_rdata <= addr0_q ? rom_rdata
                           : {rom_rdata[`MCU_DATA_W-1:0], rom_rdata[`ROM_DATA_W-1:`MCU_DATA_W]};
    end
    if (state == MCU_RD) begin
      mcu_rdata <= acc_addr[0] ? rom_rdata[`MCU_DATA_W-1:0]
                               : rom_rdata[`ROM_DATA_W-1:`MCU_DATA_W];
    end
  end

endmodule

// ==== rom_arbiter_top.sv ====
`timescale 1ns/10ps
`include "rom_arbiter_defines.svh"

module rom_arbiter_top import snes_bus_pkg::*, rom_req_pkg::*; #(
  parameter int dead_timeout = `DEAD_TIMEOUT
) (
  input  logic                   clk,
  input  logic                   rst,
  // console side
  input  logic                   cpu_clk_in,
  input  snes_addr_t             mapped_addr,
  input  logic                   rom_hit,
  input  logic                   gsu_ron,
  // gsu
  input  logic                   gsu_rrq,
  input  gsu_req_t               gsu_req,
  output logic                   gsu_rdy,
  output logic [`ROM_DATA_W-1:0] gsu_rdata,
  // mcu
  input  logic                   mcu_rq,
  input  mcu_req_t               mcu_req,
  output logic                   mcu_rdy,
  output logic [`MCU_DATA_W-1:0] mcu_rdata,
  // rom
  output rom_pins_t              rom,
  input  logic [`ROM_DATA_W-1:0] rom_rdata
);

  bus_evt_t evt;
  logic     gsu_pend;
  logic     mcu_pend;
  gsu_req_t gsu_held;
  mcu_req_t mcu_held;
  logic     gsu_done;
  logic     mcu_done;

  snes_bus_sync #(.dead_timeout(dead_timeout)) i_sync (
    .clk        (clk),
    .rst        (rst),
    .cpu_clk_in (cpu_clk_in),
    .rom_hit    (rom_hit),
    .gsu_ron    (gsu_ron),
    .evt        (evt)
  );

  req_slot #(.payload_t(gsu_req_t)) i_gsu_slot (
    .clk     (clk),
    .rst     (rst),
    .req     (gsu_rrq),
    .payload (gsu_req),
    .done    (gsu_done),
    .rdy     (gsu_rdy),
    .pend    (gsu_pend),
    .held    (gsu_held)
  );

  req_slot #(.payload_t(mcu_req_t)) i_mcu_slot (
    .clk     (clk),
    .rst     (rst),
    .req     (mcu_rq),
    .payload (mcu_req),
    .done    (mcu_done),
    .rdy     (mcu_rdy),
    .pend    (mcu_pend),
    .held    (mcu_held)
  );

  rom_sequencer i_seq (
    .clk         (clk),
    .rst         (rst),
    .evt         (evt),
    .mapped_addr (mapped_addr),
    .gsu_pend    (gsu_pend),
    .gsu_held    (gsu_held),
    .mcu_pend    (mcu_pend),
    .mcu_held    (mcu_held),
    .gsu_done    (gsu_done),
    .mcu_done    (mcu_done),
    .rom         (rom),
    .rom_rdata   (rom_rdata),
    .gsu_rdata   (gsu_rdata),
    .mcu_rdata   (mcu_rdata)
  );

endmodule

// ==== rom_arbiter_props.sv ====
`timescale 1ns/10ps

module rom_arbiter_props import rom_req_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      gsu_rrq,
  input logic      gsu_rdy,
  input logic      mcu_rq,
  input logic      mcu_rdy,
  input rom_pins_t rom
);

  int prop_fails = 0;

  // strobes only while the slot is free
  gsu_strobe_ok: assert property (@(posedge clk) disable iff (rst) gsu_rrq |-> gsu_rdy)
    else begin
      prop_fails++;
      $error("gsu strobe while gsu_rdy low");
    end

  mcu_strobe_ok: assert property (@(posedge clk) disable iff (rst) mcu_rq |-> mcu_rdy)
    else begin
      prop_fails++;
      $error("mcu strobe while mcu_rdy low");
    end

  // only the gsu busy, so no write may be on the pins
  no_gsu_write: assert property (@(posedge clk) disable iff (rst)
      (!gsu_rdy && mcu_rdy) |-> rom.we_n)
    else begin
      prop_fails++;
      $error("we_n low with only a gsu read outstanding");
    end

  // mcu byte access enables exactly one lane
  lane_on: assert property (@(posedge clk) disable iff (rst)
      (gsu_rdy && !mcu_rdy) |-> (rom.bhe_n != rom.ble_n))
    else begin
      prop_fails++;
      $error("mcu access with both or no byte lane enabled");
    end

endmodule

// ==== tb_rom_arbiter.sv ====
`timescale 1ns/10ps
`include "rom_arbiter_defines.svh"

module tb_rom_arbiter import snes_bus_pkg::*, rom_req_pkg::*; ();

  localparam int          CPU_HALF   = 12;  // CLK2 cycles per cpu clock phase
  localparam int          ACC_CYC    = `ROM_CYCLE_LEN + 1;
  localparam int          DEAD_CYC   = 200;
  localparam int          MAX_CYCLES = 4000;  // all tests need roughly a quarter of this
  localparam logic [31:0] SEED       = 32'h338f3d8f;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   cpu_clk_in = 1'b0;
  logic                   cpu_run;
  int                     cpu_div = 0;
  snes_addr_t             mapped_addr;
  logic                   rom_hit;
  logic                   gsu_ron;
  logic                   gsu_rrq;
  gsu_req_t               gsu_req;
  logic                   gsu_rdy;
  logic [`ROM_DATA_W-1:0] gsu_rdata;
  logic                   mcu_rq;
  mcu_req_t               mcu_req;
  logic                   mcu_rdy;
  logic [`MCU_DATA_W-1:0] mcu_rdata;
  rom_pins_t              rom;
  logic [`ROM_DATA_W-1:0] rom_rdata;

  logic [15:0] rom_mem [0:255];  // small rom, upper address bits ignored
  logic [31:0] fill_seed;
  logic [31:0] addr_seed;
  int          cycles = 0;
  int          data_errs = 0;
  int          proto_errs = 0;
  int          we_low_cnt = 0;
  int          both_lane_cnt = 0;
  int          gsu_rise_cyc;
  int          mcu_rise_cyc;
  logic        gsu_rdy_q = 1'b1;
  logic        mcu_rdy_q = 1'b1;
  logic [15:0] gsu_exp_q[$];
  logic        gsu_word_q[$];
  logic [7:0]  mcu_exp_q[$];
  logic        mcu_chk_q[$];  // 0 for writes, nothing to compare

  rom_arbiter_top #(.dead_timeout(DEAD_CYC)) i_dut (
    .clk(clk), .rst(rst), .cpu_clk_in(cpu_clk_in), .mapped_addr(mapped_addr),
    .rom_hit(rom_hit), .gsu_ron(gsu_ron), .gsu_rrq(gsu_rrq), .gsu_req(gsu_req),
    .gsu_rdy(gsu_rdy), .gsu_rdata(gsu_rdata), .mcu_rq(mcu_rq), .mcu_req(mcu_req),
    .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata), .rom(rom), .rom_rdata(rom_rdata)
  );

  bind rom_arbiter_top rom_arbiter_props i_props (
    .clk(clk), .rst(rst), .gsu_rrq(gsu_rrq), .gsu_rdy(gsu_rdy),
    .mcu_rq(mcu_rq), .mcu_rdy(mcu_rdy), .rom(rom)
  );

  always #2 clk = ~clk;

  // cpu clock, held low while stopped
  always @(negedge clk) begin
    if (!cpu_run) begin
      cpu_clk_in <= 1'b0;
      cpu_div    <= CPU_HALF - 1;  // rises right after a restart
    end else if (cpu_div == CPU_HALF - 1) begin
      cpu_div    <= 0;
      cpu_clk_in <= ~cpu_clk_in;
    end else begin
      cpu_div <= cpu_div + 1;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic snes_addr_t rand_addr();
    addr_seed = lcg_next(addr_seed);
    return snes_addr_t'(addr_seed[24:16]);  // 9 bit byte address
  endfunction

  // ------------------------------
  // rom model and reference
  // ------------------------------
  assign rom_rdata = rom_mem[rom.addr[7:0]];

  always @(posedge clk) begin
    if (rst) begin
      fill_seed = SEED;
      for (int i = 0; i < 256; i++) begin
        fill_seed = lcg_next(fill_seed);
        rom_mem[i] <= fill_seed[31:16];
      end
    end else if (!rom.we_n) begin
      if (!rom.ble_n) rom_mem[rom.addr[7:0]][7:0] <= rom.wdata[7:0];
      if (!rom.bhe_n) rom_mem[rom.addr[7:0]][15:8] <= rom.wdata[15:8];
      we_low_cnt <= we_low_cnt + 1;
    end
    if (!rom.bhe_n && !rom.ble_n) both_lane_cnt <= both_lane_cnt + 1;
  end

  // odd byte on [7:0], even byte address comes back swapped
  function automatic logic [15:0] gsu_expect(input snes_addr_t addr);
    logic [15:0] w;
    w = rom_mem[addr[8:1]];
    return addr[0] ? w : {w[7:0], w[15:8]};
  endfunction

  function automatic logic [7:0] mcu_expect(input snes_addr_t addr);
    logic [15:0] w;
    w = rom_mem[addr[8:1]];
    return addr[0] ? w[7:0] : w[15:8];
  endfunction

  // ------------------------------
  // compare on rdy rise
  // ------------------------------
  always @(negedge clk) begin
    if (gsu_rdy && !gsu_rdy_q) begin
      gsu_rise_cyc = cycles;
      if (gsu_exp_q.size() == 0) begin
        proto_errs++;
        $display("gsu ready rose at %0t with no request outstanding", $time);
      end else begin
        assert (gsu_word_q[0] ? (gsu_rdata == gsu_exp_q[0])
                              : (gsu_rdata[7:0] == gsu_exp_q[0][7:0])) else begin
          data_errs++;
          $display("ERROR t=%0t gsu_rdata got %h exp %h (word %b)",
                   $time, gsu_rdata, gsu_exp_q[0], gsu_word_q[0]);
        end
        void'(gsu_exp_q.pop_front());
        void'(gsu_word_q.pop_front());
      end
    end
    if (mcu_rdy && !mcu_rdy_q) begin
      mcu_rise_cyc = cycles;
      if (mcu_exp_q.size() == 0) begin
        proto_errs++;
        $display("mcu ready rose at %0t with no request outstanding", $time);
      end else begin
        assert (!mcu_chk_q[0] || mcu_rdata == mcu_exp_q[0]) else begin
          data_errs++;
          $display("ERROR t=%0t mcu_rdata got %h exp %h", $time, mcu_rdata, mcu_exp_q[0]);
        end
        void'(mcu_exp_q.pop_front());
        void'(mcu_chk_q.pop_front());
      end
    end
    gsu_rdy_q <= gsu_rdy;
    mcu_rdy_q <= mcu_rdy;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // stimulus tasks
  // ------------------------------
  task automatic start_gsu(input snes_addr_t addr, input logic word);
    gsu_exp_q.push_back(gsu_expect(addr));
    gsu_word_q.push_back(word);
    gsu_req <= '{addr: addr, word: word};
    gsu_rrq <= 1'b1;
  endtask

  task automatic start_mcu(input snes_addr_t addr, input logic write, input logic [7:0] wdata,
                           input logic [7:0] exp);
    mcu_exp_q.push_back(exp);
    mcu_chk_q.push_back(!write);
    mcu_req <= '{addr: addr, write: write, wdata: wdata};
    mcu_rq  <= 1'b1;
  endtask

  task automatic end_strobes();
    @(negedge clk);
    gsu_rrq <= 1'b0;
    mcu_rq  <= 1'b0;
  endtask

  task automatic wait_gsu();
    while (!gsu_rdy) @(negedge clk);
  endtask

  task automatic wait_mcu();
    while (!mcu_rdy) @(negedge clk);
  endtask

  task automatic gsu_read(input snes_addr_t addr, input logic word);
    int lanes0;
    lanes0 = both_lane_cnt;
    start_gsu(addr, word);
    end_strobes();
    wait_gsu();
    assert (both_lane_cnt - lanes0 == (word ? ACC_CYC : 0)) else begin
      proto_errs++;
      $display("ERROR t=%0t both-lane cycles got %0d exp %0d",
               $time, both_lane_cnt - lanes0, word ? ACC_CYC : 0);
    end
  endtask

  task automatic mcu_access(input snes_addr_t addr, input logic write, input logic [7:0] wdata,
                            input logic [7:0] exp);
    int we0;
    we0 = we_low_cnt;
    start_mcu(addr, write, wdata, exp);
    end_strobes();
    wait_mcu();
    assert (we_low_cnt - we0 == (write ? ACC_CYC : 0)) else begin
      proto_errs++;
      $display("ERROR t=%0t we_n low cycles got %0d exp %0d",
               $time, we_low_cnt - we0, write ? ACC_CYC : 0);
    end
  endtask

  initial begin
    snes_addr_t a;
    snes_addr_t b;
    rst         = 1'b1;
    cpu_run     = 1'b1;
    mapped_addr = 24'h000100;
    rom_hit     = 1'b0;
    gsu_ron     = 1'b0;
    gsu_rrq     = 1'b0;
    gsu_req     = '0;
    mcu_rq      = 1'b0;
    mcu_req     = '0;
    addr_seed   = SEED;
    repeat (4) @(negedge clk);
    rst <= 1'b0;
    @(negedge clk);

    assert (gsu_rdy && mcu_rdy && rom.we_n) else begin
      proto_errs++;
      $display("ERROR t=%0t after reset gsu_rdy %b mcu_rdy %b we_n %b",
               $time, gsu_rdy, mcu_rdy, rom.we_n);
    end

    // gsu byte and word reads, odd and even
    for (int i = 0; i < 8; i++) begin
      a    = rand_addr();
      a[0] = i[0];
      gsu_read(a, i[1]);
    end

    // mcu write then read back, both lanes of one word
    a    = rand_addr();
    a[0] = 1'b1;
    mcu_access(a, 1'b1, 8'h5a, 8'h00);
    mcu_access(a, 1'b0, 8'h00, 8'h5a);
    a[0] = 1'b0;
    mcu_access(a, 1'b1, 8'ha5, 8'h00);
    mcu_access(a, 1'b0, 8'h00, 8'ha5);
    assert (rom_mem[a[8:1]] == 16'ha55a) else begin
      data_errs++;
      $display("ERROR t=%0t rom word got %h exp a55a", $time, rom_mem[a[8:1]]);
    end

    // both pending in the same cycle, gsu has priority
    a = rand_addr();
    b = rand_addr();
    start_gsu(a, 1'b1);
    start_mcu(b, 1'b0, 8'h00, mcu_expect(b));
    end_strobes();
    wait_gsu();
    wait_mcu();
    @(negedge clk);
    assert (gsu_rise_cyc < mcu_rise_cyc) else begin
      proto_errs++;
      $display("ERROR t=%0t gsu done at %0d, mcu at %0d", $time, gsu_rise_cyc, mcu_rise_cyc);
    end

    // console on rom every cycle
    rom_hit <= 1'b1;
    gsu_read(rand_addr(), 1'b0);
    a = rand_addr();
    mcu_access(a, 1'b0, 8'h00, mcu_expect(a));
    rom_hit <= 1'b0;

    // stopped cpu clock, served once dead
    cpu_run <= 1'b0;
    repeat (DEAD_CYC + 20) @(negedge clk);
    gsu_read(rand_addr(), 1'b1);
    a = rand_addr();
    mcu_access(a, 1'b0, 8'h00, mcu_expect(a));

    // clock returns in the middle of a gsu access
    start_gsu(rand_addr(), 1'b1);
    end_strobes();
    repeat (2) @(negedge clk);
    cpu_run <= 1'b1;
    wait_gsu();

    repeat (4) @(negedge clk);
    $display("errors: data %0d protocol %0d assertion %0d",
             data_errs, proto_errs, i_dut.i_props.prop_fails);
    if (data_errs == 0 && proto_errs == 0 && i_dut.i_props.prop_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== rom_arbiter.f ====
+incdir+.
snes_bus_pkg.sv
rom_req_pkg.sv
snes_bus_sync.sv
req_slot.sv
rom_sequencer.sv
rom_arbiter_top.sv
rom_arbiter_props.sv
tb_rom_arbiter.sv

// ==== Bender.yml ====
package:
  name: rom_arbiter

sources:
  - include_dirs:
      - .
    files:
      - snes_bus_pkg.sv
      - rom_req_pkg.sv
      - snes_bus_sync.sv
      - req_slot.sv
      - rom_sequencer.sv
      - rom_arbiter_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rom_arbiter_props.sv
      - tb_rom_arbiter.sv
